// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       := fetch_tb
FILELIST  := rv_fetch.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL
PASS_MSG  := RESULT: PASS
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rv_fetch.f ====
verilog/fetch_pkg.sv
verilog/pc_sequencer.sv
verilog/fetch_unit.sv
verilog/rvc_expander.sv
verilog/fetch_top.sv
testbench/fetch_assert.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_assert.sv ====
// Sampled on the rising clock edge and only active when the simulator runs with assertions on
module fetch_assert import fetch_pkg::*; (
	input logic       clock,
	input logic       reset,
	input addr_t      iaddr,
	input logic       ivalid,
	input logic       iready,
	input logic       fetch_valid,
	input fetch_out_t fetch_out,
	input consume_t   consume
);

	// Bus request holds until iready
	bus_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else $error("bus request changed before iready");

	// Offered instruction holds until the consumer takes it
	out_hold: assert property (@(posedge clock) disable iff (reset)
		fetch_valid && !consume.ready |=> fetch_valid && $stable(fetch_out))
		else $error("fetch output changed under back-pressure");

	reset_quiet: assert property (@(posedge clock) reset |=> !fetch_valid)
		else $error("fetch_valid high right after reset");

	// First read goes to the reset address
	reset_read: assert property (@(posedge clock) reset |=> ivalid && iaddr == reset_pc)
		else $error("no read of the reset address after reset");

	word_aligned: assert property (@(posedge clock) disable iff (reset) iaddr[1:0] == 2'b00)
		else $error("bus address not word aligned");

endmodule

bind fetch_top fetch_assert u_assert (
	.clock       (clock),
	.reset       (reset),
	.iaddr       (iaddr),
	.ivalid      (ivalid),
	.iready      (iready),
	.fetch_valid (fetch_valid),
	.fetch_out   (fetch_out),
	.consume     (consume)
);

// ==== testbench/fetch_tb.sv ====
// Memory model is 1 KB and wraps, redirect targets stay inside it, all stimulus from one LFSR
module fetch_tb import fetch_pkg::*; ();

	localparam int clock_period  = 20;
	localparam int reset_cycles  = 16;
	localparam int drive_delay   = 2;
	localparam int num_transfers = 2000;
	localparam int watchdog_time = (reset_cycles + num_transfers * 40) * clock_period;

	logic        clock;
	logic        reset;
	addr_t       iaddr;
	logic        ivalid;
	logic [31:0] idata;
	logic        iready;
	logic        fetch_valid;
	fetch_out_t  fetch_out;
	consume_t    consume;

	logic [31:0] mem [0:255];    // Instruction memory
	logic [31:0] lfsr_state;

	fetch_top DUT (
		.clock       (clock),
		.reset       (reset),
		.iaddr       (iaddr),
		.ivalid      (ivalid),
		.idata       (idata),
		.iready      (iready),
		.fetch_valid (fetch_valid),
		.fetch_out   (fetch_out),
		.consume     (consume)
	);

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int count, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic put_half(input int index, input logic [15:0] h);
		if (index % 2 == 1) mem[index / 2][31:16] = h;
		else mem[index / 2][15:0] = h;
	endtask

	// Forces the fixed fields of one of the six supported forms onto random bits
	function automatic logic [15:0] make_supported(input logic [2:0] op, input logic [15:0] h);
		logic [4:0] rs2;
		rs2 = (h[6:2] == 5'd0) ? 5'd1 : h[6:2]; // Zero would be C.JR
		case (op)
			3'd0: make_supported = {3'b000, h[12:2], 2'b01};         // C.ADDI
			3'd1: make_supported = {3'b010, h[12:2], 2'b01};         // C.LI
			3'd2: make_supported = {4'b1000, h[11:7], rs2, 2'b10};   // C.MV
			3'd3: make_supported = {4'b1001, h[11:7], rs2, 2'b10};   // C.ADD
			3'd4: make_supported = {3'b010, h[12:2], 2'b00};         // C.LW
			3'd5: make_supported = {3'b110, h[12:2], 2'b00};         // C.SW
			default: make_supported = {3'b011, h[12:2], 2'b01};      // C.LUI, outside the subset
		endcase
	endfunction

	// Halfword stream of compressed and 32-bit instructions
	task automatic fill_memory();
		int          idx;
		logic [31:0] kind;
		logic [31:0] r;
		logic [31:0] op;
		logic [15:0] h;
		idx = 0;
		while (idx < 512) begin
			draw_bits(2, kind);
			draw_bits(16, r);
			h = r[15:0];
			if (kind == 32'd3 && idx < 511) begin
				put_half(idx, {h[15:2], 2'b11});
				draw_bits(16, r);
				put_half(idx + 1, r[15:0]);
				idx = idx + 2;
			end else begin
				if (kind == 32'd2) begin
					if (h[1:0] == 2'b11) h[0] = 1'b0; // Any compressed pattern
				end else begin
					draw_bits(3, op);
					h = make_supported(op[2:0], h);
				end
				put_half(idx, h);
				idx = idx + 1;
			end
		end
	endtask

	function automatic logic [15:0] halfword_at(input addr_t addr);
		logic [31:0] word;
		word = mem[addr[9:2]];   // Wraps at 1 KB like the bus model
		halfword_at = addr[1] ? word[31:16] : word[15:0];
	endfunction

	// Expected consumer view of the instruction at addr
	function automatic fetch_out_t expected_out(input addr_t addr);
		fetch_out_t  e;
		logic [15:0] h;
		logic [4:0]  rd;
		logic [4:0]  rs2;
		logic [4:0]  rs1c;
		logic [4:0]  rs2c;
		logic [11:0] imm;
		logic [11:0] off;
		h = halfword_at(addr);
		e = '0;
		e.pc = addr;
		rd = h[11:7];
		rs2 = h[6:2];
		rs1c = 5'd8 + 5'(h[9:7]);
		rs2c = 5'd8 + 5'(h[4:2]);
		imm = {{7{h[12]}}, h[6:2]};
		off = 12'(h[12:10]) * 12'd8 + 12'(h[6]) * 12'd4 + 12'(h[5]) * 12'd64;
		if (h[1:0] == 2'b11) begin
			e.raw = {halfword_at(addr + 32'd2), h}; // May come from the next word
			e.instr = e.raw;
		end else begin
			e.raw = {16'h0000, h};
			e.compressed = 1'b1;
			case ({h[15:13], h[1:0]})
				5'b000_01: e.instr = {imm, rd, 3'b000, rd, 7'h13};
				5'b010_01: e.instr = {imm, 5'd0, 3'b000, rd, 7'h13};
				5'b100_10: begin
					if (rs2 == 5'd0) e.unsupported = 1'b1;
					else if (h[12]) e.instr = {7'd0, rs2, rd, 3'b000, rd, 7'h33};
					else e.instr = {7'd0, rs2, 5'd0, 3'b000, rd, 7'h33};
				end
				5'b010_00: e.instr = {off, rs1c, 3'b010, rs2c, 7'h03};
				5'b110_00: e.instr = {off[11:5], rs2c, rs1c, 3'b010, off[4:0], 7'h23};
				default: e.unsupported = 1'b1;
			endcase
		end
		expected_out = e;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		draw_bits(2, r);
		iready = (r[1:0] != 2'b00);   // Stall about one cycle in four
		idata = mem[iaddr[9:2]];
		draw_bits(2, r);
		consume.ready = (r[1:0] != 2'b00);
		draw_bits(3, r);
		consume.redirect = (r[2:0] == 3'd0); // One in eight
		draw_bits(9, r);
		consume.target = {22'd0, r[8:0], 1'b0};
	endtask

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// Reset then new inputs shortly after every rising edge
	initial begin
		reset = 1'b1;
		iready = 1'b0;
		idata = '0;
		consume = '0;
		lfsr_state = 32'hf22c65d3;
		fill_memory();
		repeat (reset_cycles) @(posedge clock);
		#drive_delay;
		reset = 1'b0;
		forever begin
			drive_inputs();
			@(posedge clock);
			#drive_delay;
		end
	end

	// Compare at the falling edge, where all sampled signals are settled
	initial begin : compare
		fetch_out_t want;
		fetch_out_t held_out;
		addr_t      held_iaddr;
		addr_t      exp_pc;
		logic       out_held;
		logic       bus_held;
		int         transfers;
		exp_pc = reset_pc;
		held_out = '0;
		held_iaddr = '0;
		out_held = 1'b0;
		bus_held = 1'b0;
		transfers = 0;
		while (transfers < num_transfers) begin
			@(negedge clock);
			if (!reset) begin
				if (out_held) assert (fetch_valid && fetch_out == held_out) else
					stop_with_failure($sformatf("Fail at time %0t: output moved while held",
						$time));
				if (bus_held) assert (ivalid && iaddr == held_iaddr) else
					stop_with_failure($sformatf("Fail at time %0t: bus request moved", $time));
				out_held = fetch_valid && !consume.ready;
				held_out = fetch_out;
				bus_held = ivalid && !iready;
				held_iaddr = iaddr;
				if (fetch_valid && consume.ready) begin
					want = expected_out(exp_pc);
					assert (fetch_out.pc == exp_pc) else
						stop_with_failure($sformatf("Fail at time %0t: pc %h, expected %h",
							$time, fetch_out.pc, exp_pc));
					assert (fetch_out == want) else
						stop_with_failure($sformatf(
							"Fail at time %0t: pc %h raw %h instr %h c%b u%b, expected %h %h c%b u%b",
							$time, exp_pc, fetch_out.raw, fetch_out.instr, fetch_out.compressed,
							fetch_out.unsupported, want.raw, want.instr, want.compressed,
							want.unsupported));
					if (consume.redirect) exp_pc = consume.target;
					else exp_pc = exp_pc + (want.compressed ? 32'd2 : 32'd4);
					transfers++;
				end
			end
		end
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		#watchdog_time;
		stop_with_failure($sformatf("Watchdog expired: %0d transfers did not finish in time",
			num_transfers));
	end

endmodule

// ==== verilog/fetch_pkg.sv ====
// Every address is a byte address with bit 0 clear and reset_pc must be word aligned
package fetch_pkg;

	// Address of the first instruction after reset
	localparam logic [31:0] reset_pc = 32'h0000_0000;

	// Base opcodes of the expanded 32-bit forms
	localparam logic [6:0] opc_op_imm = 7'b0010011; // ADDI
	localparam logic [6:0] opc_op     = 7'b0110011; // ADD
	localparam logic [6:0] opc_load   = 7'b0000011; // LW
	localparam logic [6:0] opc_store  = 7'b0100011; // SW

	// funct3 of the expanded forms
	localparam logic [2:0] f3_add  = 3'b000; // ADD and ADDI
	localparam logic [2:0] f3_word = 3'b010; // LW and SW

	// Quadrant of a compressed halfword, taken from its two low bits
	localparam logic [1:0] quad_0 = 2'b00;
	localparam logic [1:0] quad_1 = 2'b01;
	localparam logic [1:0] quad_2 = 2'b10; // 2'b11 marks a 32-bit instruction

	// Byte address, bit 0 stays zero
	typedef logic [31:0] addr_t;

	// Supported compressed instructions
	typedef enum logic [2:0] {
		op_addi,  // Q1 funct3 000
		op_li,    // Q1 funct3 010
		op_mv,    // Q2 funct3 100 with bit 12 clear
		op_add,   // Q2 funct3 100 with bit 12 set
		op_lw,    // Q0 funct3 010
		op_sw,    // Q0 funct3 110
		op_other  // Anything else
	} rvc_op_e;

	// What the consumer sees with fetch_valid
	typedef struct packed {
		addr_t       pc;          // Instruction address
		logic [31:0] raw;         // Fetched bits, upper half zero when compressed
		logic [31:0] instr;       // Expanded form
		logic        compressed;  // 16-bit instruction
		logic        unsupported; // 16-bit pattern outside the subset
	} fetch_out_t;

	// Consumer response, only sampled on a transfer
	typedef struct packed {
		logic  ready;    // Instruction taken
		logic  redirect; // Next address is target
		addr_t target;   // Even address
	} consume_t;

	// A halfword starts a compressed instruction unless its low bits are 11
	function automatic logic is_rvc(input logic [1:0] low_bits);
		is_rvc = (low_bits != 2'b11);
	endfunction

endpackage

// ==== verilog/fetch_top.sv ====
// Fetch front end with no added latency that relies on the bus holding idata valid in the iready cycle
module fetch_top import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	output addr_t       iaddr,
	output logic        ivalid,
	input  logic [31:0] idata,
	input  logic        iready,
	output logic        fetch_valid,
	output fetch_out_t  fetch_out,
	input  consume_t    consume
);

	addr_t       pc;
	logic        next_seq;
	logic        accept;
	logic        is_c;
	logic [31:0] raw;
	logic [31:0] exp_instr;
	logic        exp_unsupported;

	pc_sequencer u_seq (
		.clock    (clock),
		.reset    (reset),
		.accept   (accept),
		.is_c     (is_c),
		.consume  (consume),
		.pc       (pc),
		.next_seq (next_seq)
	);

	fetch_unit u_fetch (
		.clock       (clock),
		.reset       (reset),
		.pc          (pc),
		.next_seq    (next_seq),
		.iaddr       (iaddr),
		.ivalid      (ivalid),
		.idata       (idata),
		.iready      (iready),
		.fetch_valid (fetch_valid),
		.ready       (consume.ready),
		.accept      (accept),
		.raw         (raw),
		.is_c        (is_c)
	);

	rvc_expander u_exp (
		.raw_lo      (raw[15:0]),
		.is_c        (is_c),
		.instr       (exp_instr),
		.unsupported (exp_unsupported)
	);

	assign fetch_out.pc          = pc;
	assign fetch_out.raw         = raw;
	// raw[31:16] is zero for a compressed instruction, so this only completes 32-bit words
	assign fetch_out.instr       = exp_instr | {raw[31:16], 16'h0000};
	assign fetch_out.compressed  = is_c;
	assign fetch_out.unsupported = exp_unsupported;

endmodule

// ==== verilog/fetch_unit.sv ====
// Issues only word-aligned reads with at most one read open and assumes pc is always even
module fetch_unit import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  addr_t       pc,          // Address of the instruction in flight
	input  logic        next_seq,    // Following instruction is sequential
	output addr_t       iaddr,       // Word aligned
	output logic        ivalid,
	input  logic [31:0] idata,
	input  logic        iready,
	output logic        fetch_valid, // Instruction offered
	input  logic        ready,       // Consumer takes it
	output logic        accept,      // Transfer cycle
	output logic [31:0] raw,         // Assembled instruction bits
	output logic        is_c         // Compressed
);

	typedef enum logic [1:0] {
		st_fetch,   // Read the word holding pc
		st_upper,   // Read the next word for the upper half of a 32-bit instruction
		st_present  // Waiting for the consumer
	} state_e;

	state_e      state;
	logic [31:0] raw_q;
	logic        is_c_q;
	logic [15:0] keep;       // Upper halfword of the last word read
	logic        keep_valid; // keep holds the halfword at the next sequential pc
	logic        keep_c;
	logic        bus_done;   // Read completes this cycle
	logic [15:0] half;       // Halfword at pc within idata
	logic        half_c;
	logic [29:0] word_idx;   // Word address of pc

	assign word_idx = pc[31:2];

	// Upper read always targets the word after the one holding pc
	assign iaddr = (state == st_upper) ? {word_idx + 30'd1, 2'b00} : {word_idx, 2'b00};

	assign ivalid      = (state != st_present);
	assign bus_done    = ivalid && iready;
	assign fetch_valid = (state == st_present);
	assign accept      = fetch_valid && ready;

	assign half   = pc[1] ? idata[31:16] : idata[15:0];
	assign half_c = is_rvc(half[1:0]);
	assign keep_c = is_rvc(keep[1:0]);

	assign raw  = raw_q;
	assign is_c = is_c_q;

	// Control state
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_fetch;
			keep_valid <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (bus_done) begin
						// Only an aligned compressed instruction leaves a usable upper half
						keep_valid <= !pc[1] && half_c;
						if (pc[1] && !half_c) begin
							state <= st_upper; // Crosses into the next word
						end else begin
							state <= st_present;
						end
					end
				end
				st_upper: begin
					if (bus_done) begin
						keep_valid <= 1'b1; // idata[31:16] follows this instruction
						state      <= st_present;
					end
				end
				st_present: begin
					if (ready) begin
						keep_valid <= 1'b0;
						if (next_seq && keep_valid) begin
							// Next instruction starts in keep
							if (keep_c) begin
								state <= st_present; // Whole instruction already here
							end else begin
								state <= st_upper;   // Only the upper half is missing
							end
						end else begin
							state <= st_fetch; // Redirect or nothing kept
						end
					end
				end
				default: begin
					state <= st_fetch;
				end
			endcase
		end
	end

	// Instruction bits and the kept halfword
	always_ff @(posedge clock) begin
		case (state)
			st_fetch: begin
				if (bus_done) begin
					is_c_q <= half_c;
					keep   <= idata[31:16];
					if (half_c) begin
						raw_q <= {16'h0000, half};
					end else if (!pc[1]) begin
						raw_q <= idata;       // Aligned 32-bit
					end else begin
						raw_q[15:0] <= half;  // Lower half now, upper next read
					end
				end
			end
			st_upper: begin
				if (bus_done) begin
					raw_q[31:16] <= idata[15:0];
					keep         <= idata[31:16];
				end
			end
			st_present: begin
				if (ready && next_seq && keep_valid) begin
					// Upper half stays zero until st_upper fills it
					is_c_q <= keep_c;
					raw_q  <= {16'h0000, keep};
				end
			end
			default: begin
				raw_q <= raw_q;
			end
		endcase
	end

endmodule

// ==== verilog/pc_sequencer.sv ====
// Advances only on a transfer and expects every redirect target to be even
module pc_sequencer import fetch_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     accept,   // Transfer cycle
	input  logic     is_c,     // Size of the instruction being transferred
	input  consume_t consume,  // Consumer response
	output addr_t    pc,       // Address of the instruction in flight
	output logic     next_seq  // Following instruction is sequential
);

	addr_t       pc_q;
	addr_t       seq_pc;      // Fall-through address
	addr_t       target_even;
	logic [31:0] step;

	// Two bytes for a compressed instruction, else four
	assign step = is_c ? 32'd2 : 32'd4;

	assign seq_pc = pc_q + step;

	// Bit 0 is forced clear, a target is even by contract anyway
	assign target_even = {consume.target[31:1], 1'b0};

	// Fetch unit decides on this and never sees the redirect field itself
	assign next_seq = !consume.redirect;

	assign pc = pc_q;

	// Address register
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= reset_pc;
		end else if (accept) begin
			if (consume.redirect) begin
				pc_q <= target_even;  // Jump
			end else begin
				pc_q <= seq_pc;       // Sequential
			end
		end
	end

	// Held otherwise, so the consumer sees a stable pc under back-pressure

endmodule

// ==== verilog/rvc_expander.sv ====
// Expands C.ADDI C.LI C.MV C.ADD C.LW C.SW only and leaves the upper half of a 32-bit word to the caller
module rvc_expander import fetch_pkg::*; (
	input  logic [15:0] raw_lo,      // Low halfword of the instruction
	input  logic        is_c,        // raw_lo is a whole compressed instruction
	output logic [31:0] instr,       // Expanded form
	output logic        unsupported  // Compressed but outside the subset
);

	rvc_op_e     op;
	logic [1:0]  quad;
	logic [2:0]  funct3;
	logic [4:0]  rd;        // Full register fields
	logic [4:0]  rs2;
	logic [4:0]  reg_p_lo;  // x8..x15 from bits 4:2
	logic [4:0]  reg_p_hi;  // x8..x15 from bits 9:7
	logic [11:0] imm_sx;    // Sign-extended six-bit immediate
	logic [11:0] word_off;  // Word-scaled offset of C.LW and C.SW

	assign quad   = raw_lo[1:0];
	assign funct3 = raw_lo[15:13];
	assign rd     = raw_lo[11:7];
	assign rs2    = raw_lo[6:2];

	// Three-bit fields address x8..x15
	assign reg_p_lo = {2'b01, raw_lo[4:2]};
	assign reg_p_hi = {2'b01, raw_lo[9:7]};

	assign imm_sx = {{6{raw_lo[12]}}, raw_lo[12], raw_lo[6:2]};

	// uimm[6] at bit 5, uimm[5:3] at 12:10, uimm[2] at bit 6
	assign word_off = {5'b00000, raw_lo[5], raw_lo[12:10], raw_lo[6], 2'b00};

	// Classify by quadrant and funct3
	always_comb begin
		op = op_other;
		case (quad)
			quad_0: begin
				if (funct3 == 3'b010) begin
					op = op_lw;
				end else if (funct3 == 3'b110) begin
					op = op_sw;
				end
			end
			quad_1: begin
				if (funct3 == 3'b000) begin
					op = op_addi; // rd of zero is a NOP, same expansion
				end else if (funct3 == 3'b010) begin
					op = op_li;
				end
			end
			quad_2: begin
				// rs2 of zero would be C.JR, C.JALR or C.EBREAK
				if (funct3 == 3'b100 && rs2 != 5'd0) begin
					if (raw_lo[12]) begin
						op = op_add;
					end else begin
						op = op_mv;
					end
				end
			end
			default: begin
				op = op_other; // 32-bit encoding
			end
		endcase
	end

	// Build the 32-bit form
	always_comb begin
		instr       = 32'h0000_0000;
		unsupported = 1'b0;
		if (!is_c) begin
			instr = {16'h0000, raw_lo}; // Low half only, upper half joined in fetch_top
		end else begin
			case (op)
				op_addi: begin
					instr = {imm_sx, rd, f3_add, rd, opc_op_imm};   // ADDI rd, rd, imm
				end
				op_li: begin
					instr = {imm_sx, 5'd0, f3_add, rd, opc_op_imm}; // ADDI rd, x0, imm
				end
				op_mv: begin
					instr = {7'd0, rs2, 5'd0, f3_add, rd, opc_op};  // ADD rd, x0, rs2
				end
				op_add: begin
					instr = {7'd0, rs2, rd, f3_add, rd, opc_op};    // ADD rd, rd, rs2
				end
				op_lw: begin
					instr = {word_off, reg_p_hi, f3_word, reg_p_lo, opc_load};
				end
				op_sw: begin
					// S-type splits the offset around the registers
					instr = {word_off[11:5], reg_p_lo, reg_p_hi, f3_word,
						word_off[4:0], opc_store};
				end
				default: begin
					unsupported = 1'b1; // instr stays zero
				end
			endcase
		end
	end

endmodule
